//--- Makefile
# Verilator build and run for the store control unit

VERILATOR ?= verilator
TOP       ?= tb_mcu_store
FILELIST  ?= mcu_store.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/emul_calc.sv
/*
  Effective register group multiplier lookup
  from element width, lmul and sew
*/
`timescale 1ns/100ps

module emul_calc import mcu_pkg::*; (
  input  logic [VTYPE_W-1:0] eew_code_i,
  input  logic [VTYPE_W-1:0] lmul_i,
  input  logic [VTYPE_W-1:0] sew_i,
  output logic [VTYPE_W-1:0] emul_o,
  output logic               emul_valid_o
);

  logic signed [EMUL_SUM_W-1:0] lmul_log2;
  logic signed [EMUL_SUM_W-1:0] eew_log2;
  logic signed [EMUL_SUM_W-1:0] sew_log2;
  logic signed [EMUL_SUM_W-1:0] emul_log2;

  // lmul codes are already two's complement log2 values
  assign lmul_log2 = $signed(lmul_i);

  // Width codes count up from 8 bits, so the code is the log2 ratio
  assign eew_log2 = $signed(EMUL_SUM_W'(eew_code_i));
  assign sew_log2 = $signed(EMUL_SUM_W'(sew_i));

  // emul = lmul * eew / sew, done in the log domain
  assign emul_log2 = lmul_log2 + eew_log2 - sew_log2;

  // Back to the 3-bit lmul encoding
  assign emul_o = emul_log2[VTYPE_W-1:0];

  // Out of range results wrap in emul_o, so flag them here
  assign emul_valid_o = (lmul_i != LMUL_RESERVED) &&
                        (emul_log2 >= EMUL_LOG2_MIN) &&
                        (emul_log2 <= EMUL_LOG2_MAX);

endmodule

//--- design/mcu_pkg.sv
/*
  Widths, store mode and FSM state encodings, and emul range constants
  shared by the store control unit
*/
package mcu_pkg;

  ////////////////////
  // Widths

  // sew, lmul and data width codes
  localparam int VTYPE_W = 3;
  // Scheduler word and byte address width
  localparam int ADDR_W = 32;

  ////////////////////
  // Emul encoding

  // lmul is a signed log2 value, this code has no meaning
  localparam logic [VTYPE_W-1:0] LMUL_RESERVED = 3'd4;
  // Legal emul lies between 1/8 and 8
  localparam int EMUL_LOG2_MIN = -3;
  localparam int EMUL_LOG2_MAX = 3;
  // Holds lmul + eew - sew without overflow
  localparam int EMUL_SUM_W = 5;

  ////////////////////
  // Modes and states

  // Built as {unit, strided, indexed} from the scheduler strobes
  typedef enum logic [2:0] {
    MODE_NONE    = 3'b000,
    MODE_INDEXED = 3'b001,
    MODE_STRIDED = 3'b010,
    MODE_UNIT    = 3'b100
  } store_mode_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_BUFFED,
    WR_ACTIVE,
    WR_WAIT
  } store_wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_UNIT,
    RD_STRIDED,
    RD_STRIDED_STEP
  } store_rd_state_e;

endpackage

//--- design/mcu_store.sv
/*
  Store half of the vector memory control unit
*/
`timescale 1ns/100ps

module mcu_store import mcu_pkg::*; #(
  parameter int VLEN = 8192
) (
  input  logic                    clk,
  input  logic                    rstn,
  // Scheduler
  input  logic [VTYPE_W-1:0]      mcu_sew_i,
  input  logic [VTYPE_W-1:0]      mcu_lmul_i,
  input  logic [VTYPE_W-1:0]      mcu_data_width_i,
  input  logic                    mcu_unit_ld_st_i,
  input  logic                    mcu_strided_ld_st_i,
  input  logic                    mcu_idx_ld_st_i,
  input  logic [ADDR_W-1:0]       mcu_vl_i,
  input  logic                    mcu_st_vld_i,
  output logic                    mcu_st_rdy_o,
  // Buffer configuration
  output logic [VTYPE_W-1:0]      cfg_store_data_sew_o,
  output logic [VTYPE_W-1:0]      cfg_store_data_lmul_o,
  output logic [VTYPE_W-1:0]      cfg_store_idx_sew_o,
  output logic [VTYPE_W-1:0]      cfg_store_idx_lmul_o,
  output logic [$clog2(VLEN)-1:0] cfg_store_vl_o,
  output store_mode_e             store_type_o,
  // Buffer control
  output logic                    store_cfg_update_o,
  output logic                    store_cntr_rst_o,
  output logic                    store_baseaddr_update_o,
  output logic                    sbuff_wen_o,
  output logic                    sdbuff_ren_o,
  output logic                    sdbuff_read_stall_o,
  input  logic                    sdbuff_write_done_i,
  input  logic                    sdbuff_read_done_i,
  input  logic                    sdbuff_read_rdy_i,
  // Vector lanes
  input  logic                    vlane_store_dvalid_i,
  output logic                    vlane_store_rdy_o,
  // AXI write streamer
  output logic                    ctrl_wstart_o,
  input  logic                    ctrl_wdone_i,
  output logic                    wr_tvalid_o,
  input  logic                    wr_tready_i
);

  logic [VTYPE_W-1:0] emul;
  logic               emul_valid;
  logic               capture;
  logic               read_start;
  logic               read_done;
  logic               rvalid;
  logic               block;
  logic               drained;

  emul_calc i_emul_calc (
    .eew_code_i   (mcu_data_width_i),
    .lmul_i       (mcu_lmul_i),
    .sew_i        (mcu_sew_i),
    .emul_o       (emul),
    .emul_valid_o (emul_valid)
  );

  store_cfg_capture #(
    .VLEN (VLEN)
  ) i_store_cfg_capture (
    .clk          (clk),
    .rstn         (rstn),
    .capture_i    (capture),
    .sew_i        (mcu_sew_i),
    .lmul_i       (mcu_lmul_i),
    .data_width_i (mcu_data_width_i),
    .emul_i       (emul),
    .unit_i       (mcu_unit_ld_st_i),
    .strided_i    (mcu_strided_ld_st_i),
    .idx_i        (mcu_idx_ld_st_i),
    .vl_i         (mcu_vl_i),
    .emul_valid_i (emul_valid),
    .mode_o       (store_type_o),
    .data_sew_o   (cfg_store_data_sew_o),
    .data_lmul_o  (cfg_store_data_lmul_o),
    .idx_sew_o    (cfg_store_idx_sew_o),
    .idx_lmul_o   (cfg_store_idx_lmul_o),
    .vl_o         (cfg_store_vl_o)
  );

  store_write_ctrl i_store_write_ctrl (
    .clk            (clk),
    .rstn           (rstn),
    .st_vld_i       (mcu_st_vld_i),
    .vlane_dvalid_i (vlane_store_dvalid_i),
    .write_done_i   (sdbuff_write_done_i),
    .read_done_i    (read_done),
    .st_rdy_o       (mcu_st_rdy_o),
    .capture_o      (capture),
    .cfg_update_o   (store_cfg_update_o),
    .cntr_rst_o     (store_cntr_rst_o),
    .read_start_o   (read_start),
    .sbuff_wen_o    (sbuff_wen_o),
    .vlane_rdy_o    (vlane_store_rdy_o)
  );

  store_read_ctrl i_store_read_ctrl (
    .clk               (clk),
    .rstn              (rstn),
    .start_i           (read_start),
    .mode_i            (store_type_o),
    .read_rdy_i        (sdbuff_read_rdy_i),
    .read_done_i       (sdbuff_read_done_i),
    .tready_i          (wr_tready_i),
    .wdone_i           (ctrl_wdone_i),
    .tvalid_i          (wr_tvalid_o),
    .drained_i         (drained),
    .ren_o             (sdbuff_ren_o),
    .rvalid_o          (rvalid),
    .stall_o           (sdbuff_read_stall_o),
    .block_o           (block),
    .wstart_o          (ctrl_wstart_o),
    .baseaddr_update_o (store_baseaddr_update_o),
    .done_o            (read_done)
  );

  // Same stall as the buffer read pointer
  store_rvalid_pipe i_store_rvalid_pipe (
    .clk         (clk),
    .rstn        (rstn),
    .stall_i     (sdbuff_read_stall_o),
    .rvalid_i    (rvalid),
    .read_done_i (sdbuff_read_done_i),
    .block_i     (block),
    .tvalid_o    (wr_tvalid_o),
    .drained_o   (drained)
  );

endmodule

//--- design/store_cfg_capture.sv
/*
  Store configuration registers, loaded when a command is accepted
*/
`timescale 1ns/100ps

module store_cfg_capture import mcu_pkg::*; #(
  parameter int VLEN = 8192
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    capture_i,
  input  logic [VTYPE_W-1:0]      sew_i,
  input  logic [VTYPE_W-1:0]      lmul_i,
  input  logic [VTYPE_W-1:0]      data_width_i,
  input  logic [VTYPE_W-1:0]      emul_i,
  input  logic                    unit_i,
  input  logic                    strided_i,
  input  logic                    idx_i,
  input  logic [ADDR_W-1:0]       vl_i,
  input  logic                    emul_valid_i,
  output store_mode_e             mode_o,
  output logic [VTYPE_W-1:0]      data_sew_o,
  output logic [VTYPE_W-1:0]      data_lmul_o,
  output logic [VTYPE_W-1:0]      idx_sew_o,
  output logic [VTYPE_W-1:0]      idx_lmul_o,
  output logic [$clog2(VLEN)-1:0] vl_o
);

  store_mode_e mode_in;

  assign mode_in = store_mode_e'({unit_i, strided_i, idx_i});

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mode_o      <= MODE_NONE;
      data_sew_o  <= '0;
      data_lmul_o <= '0;
      idx_sew_o   <= '0;
      idx_lmul_o  <= '0;
      vl_o        <= '0;
    end else if (capture_i) begin
      mode_o <= mode_in;
      vl_o   <= vl_i[$clog2(VLEN)-1:0];
      if (mode_in == MODE_INDEXED) begin
        // Data keeps the vtype while indices use the instruction width
        data_sew_o  <= sew_i;
        data_lmul_o <= lmul_i;
      end else begin
        // Unit and strided data uses the instruction width and emul
        data_sew_o  <= data_width_i;
        data_lmul_o <= emul_i;
      end
      // Index fields always carry the width and emul
      idx_sew_o  <= data_width_i;
      idx_lmul_o <= emul_i;
    end
  end

  // Indexed stores have no read path and emul must stay in the legal range
  a_capture_legal : assert property (@(posedge clk) disable iff (!rstn)
    capture_i |-> (mode_in != MODE_INDEXED) && emul_valid_i);

endmodule

//--- design/store_read_ctrl.sv
/*
  Store read FSM with buffer reads, back-pressure stalls, the streamer
  start pulse and strided base address steps
*/
`timescale 1ns/100ps

module store_read_ctrl import mcu_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        start_i,
  input  store_mode_e mode_i,
  input  logic        read_rdy_i,
  input  logic        read_done_i,
  input  logic        tready_i,
  input  logic        wdone_i,
  input  logic        tvalid_i,
  input  logic        drained_i,
  output logic        ren_o,
  output logic        rvalid_o,
  output logic        stall_o,
  output logic        block_o,
  output logic        wstart_o,
  output logic        baseaddr_update_o,
  output logic        done_o
);

  store_rd_state_e state_q;
  store_rd_state_e state_d;
  logic            wstart;
  logic            wstart_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q  <= RD_IDLE;
      wstart_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      wstart_q <= wstart;
    end
  end

  // Streamer wants a single cycle start per burst
  assign wstart_o = wstart && !wstart_q;

  always_comb begin
    state_d           = state_q;
    ren_o             = 1'b0;
    rvalid_o          = 1'b0;
    stall_o           = 1'b0;
    block_o           = 1'b0;
    wstart            = 1'b0;
    baseaddr_update_o = 1'b0;
    done_o            = 1'b0;

    case (state_q)
      RD_IDLE: begin
        if (start_i) begin
          state_d = (mode_i == MODE_STRIDED) ? RD_STRIDED : RD_UNIT;
        end
      end

      ////////////////////
      // Unit stride, one long burst

      RD_UNIT: begin
        wstart = 1'b1;
        if (read_rdy_i) begin
          ren_o    = 1'b1;
          rvalid_o = 1'b1;
          // Last element already on its way out
          if (read_done_i && tready_i) begin
            ren_o    = 1'b0;
            rvalid_o = 1'b0;
          end
          if (tvalid_i && !tready_i) begin
            stall_o = 1'b1;
            ren_o   = 1'b0;
          end
        end else begin
          // Buffer empty so freeze and hide whatever is in the pipe
          stall_o = 1'b1;
          block_o = 1'b1;
        end
        if (wdone_i) begin
          done_o  = 1'b1;
          state_d = RD_IDLE;
        end
      end

      ////////////////////
      // Strided, one beat per burst

      RD_STRIDED: begin
        wstart = 1'b1;
        if (read_rdy_i) begin
          ren_o    = 1'b1;
          rvalid_o = 1'b1;
          if (tvalid_i && tready_i) begin
            state_d = RD_STRIDED_STEP;
            if (read_done_i) begin
              ren_o    = 1'b0;
              rvalid_o = 1'b0;
            end
          end
          if (tvalid_i && !tready_i) begin
            stall_o = 1'b1;
            ren_o   = 1'b0;
          end
        end else begin
          stall_o = 1'b1;
          block_o = 1'b1;
        end
      end

      // Beat accepted so hold the pipe until the burst closes
      RD_STRIDED_STEP: begin
        stall_o = 1'b1;
        if (wdone_i) begin
          baseaddr_update_o = 1'b1;
          state_d           = RD_STRIDED;
          if (drained_i) begin
            done_o  = 1'b1;
            state_d = RD_IDLE;
          end
        end
      end

      default: begin
        state_d = RD_IDLE;
      end
    endcase
  end

  // The streamer closes a burst only after the beat that ends it
  a_wdone_after_beat : assert property (@(posedge clk) disable iff (!rstn)
    wdone_i |-> state_q inside {RD_UNIT, RD_STRIDED_STEP});

endmodule

//--- design/store_rvalid_pipe.sv
/*
  Read-valid delay line matching the store buffer read latency
*/
`timescale 1ns/100ps

module store_rvalid_pipe (
  input  logic clk,
  input  logic rstn,
  input  logic stall_i,
  input  logic rvalid_i,
  input  logic read_done_i,
  input  logic block_i,
  output logic tvalid_o,
  output logic drained_o
);

  logic [2:0] rvalid_q;

  // Freezes together with the buffer read pointer
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rvalid_q <= '0;
    end else if (!stall_i) begin
      rvalid_q <= {rvalid_q[1:0], rvalid_i};
    end
  end

  // Final element comes out one stage later
  always_comb begin
    tvalid_o = read_done_i ? rvalid_q[2] : rvalid_q[1];
    if (block_i) begin
      tvalid_o = 1'b0;
    end
  end

  assign drained_o = (rvalid_q == 3'b000);

endmodule

//--- design/store_write_ctrl.sv
/*
  Store write FSM with the scheduler handshake, configuration pulses
  and vector lane writes into the store data buffer
*/
`timescale 1ns/100ps

module store_write_ctrl import mcu_pkg::*; (
  input  logic clk,
  input  logic rstn,
  input  logic st_vld_i,
  input  logic vlane_dvalid_i,
  input  logic write_done_i,
  input  logic read_done_i,
  output logic st_rdy_o,
  output logic capture_o,
  output logic cfg_update_o,
  output logic cntr_rst_o,
  output logic read_start_o,
  output logic sbuff_wen_o,
  output logic vlane_rdy_o
);

  store_wr_state_e state_q;
  store_wr_state_e state_d;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    st_rdy_o     = 1'b0;
    capture_o    = 1'b0;
    cfg_update_o = 1'b0;
    cntr_rst_o   = 1'b0;
    read_start_o = 1'b0;
    sbuff_wen_o  = 1'b0;
    vlane_rdy_o  = 1'b0;

    case (state_q)
      WR_IDLE: begin
        st_rdy_o = 1'b1;
        if (st_vld_i) begin
          capture_o = 1'b1;
          state_d   = WR_BUFFED;
        end
      end

      // Registered config is stable now so tell the buffer and the read side
      WR_BUFFED: begin
        cfg_update_o = 1'b1;
        cntr_rst_o   = 1'b1;
        read_start_o = 1'b1;
        state_d      = WR_ACTIVE;
      end

      WR_ACTIVE: begin
        vlane_rdy_o = 1'b1;
        sbuff_wen_o = vlane_dvalid_i;
        if (write_done_i && vlane_dvalid_i) begin
          state_d = WR_WAIT;
        end
      end

      // Hold off the scheduler until the streamer has taken everything
      WR_WAIT: begin
        if (read_done_i) begin
          state_d = WR_IDLE;
        end
      end

      default: begin
        state_d = WR_IDLE;
      end
    endcase
  end

  // The read side only finishes once every lane write is in the buffer
  a_read_done_in_wait : assert property (@(posedge clk) disable iff (!rstn)
    read_done_i |-> state_q == WR_WAIT);

endmodule

//--- mcu_store.f
design/mcu_pkg.sv
design/emul_calc.sv
design/store_cfg_capture.sv
design/store_write_ctrl.sv
design/store_read_ctrl.sv
design/store_rvalid_pipe.sv
design/mcu_store.sv
verification/mcu_store_env.sv
verification/tb_mcu_store.sv

//--- verification/mcu_store_env.sv
/*
  Behavioral store data buffer and AXI write streamer responder
*/
`timescale 1ns/100ps

module mcu_store_env #(
  parameter int SEED = 32'hf6ac
) (
  input  logic clk,
  input  logic rstn,
  input  int   vl_i,
  input  logic strided_i,
  input  logic cntr_rst_i,
  input  logic vlane_rdy_i,
  input  logic wen_i,
  input  logic ren_i,
  input  logic wstart_i,
  input  logic tvalid_i,
  output logic dvalid_o = 1'b0,
  output logic write_done_o = 1'b0,
  output logic read_rdy_o = 1'b0,
  output logic read_done_o = 1'b0,
  output logic tready_o = 1'b0,
  output logic wdone_o = 1'b0
);

  integer seed = SEED;
  int     wr_cnt = 0;
  int     rd_cnt = 0;
  int     beats = 0;
  int     gap = 0;
  logic   armed = 1'b0;
  logic   closing = 1'b0;

  ////////////////////
  // Buffer pointers and burst state, updated on the active edge

  always @(posedge clk) begin
    closing <= 1'b0;
    if (wstart_i) begin
      armed <= 1'b1;
    end
    if (cntr_rst_i) begin
      wr_cnt <= 0;
      rd_cnt <= 0;
      beats  <= 0;
      gap    <= 1 + ($random(seed) & 7);
    end else begin
      wr_cnt <= wr_cnt + int'(wen_i);
      rd_cnt <= rd_cnt + int'(ren_i);
      // Read side opens a few cycles after the buffer is full
      if (wr_cnt == vl_i && gap > 0) begin
        gap <= gap - 1;
      end
      if (tvalid_i && tready_o) begin
        beats <= strided_i ? 0 : beats + 1;
        // Strided bursts carry a single beat
        if (strided_i || beats + 1 == vl_i) begin
          armed   <= 1'b0;
          closing <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Responses, driven on the falling edge

  always @(negedge clk) begin
    if (!rstn) begin
      dvalid_o     <= 1'b0;
      write_done_o <= 1'b0;
      read_rdy_o   <= 1'b0;
      read_done_o  <= 1'b0;
      tready_o     <= 1'b0;
      wdone_o      <= 1'b0;
    end else begin
      dvalid_o     <= vlane_rdy_i && (wr_cnt < vl_i) && (($random(seed) & 3) != 0);
      write_done_o <= (wr_cnt == vl_i - 1);
      read_rdy_o   <= (wr_cnt == vl_i) && (gap == 0) && (($random(seed) & 7) != 0);
      // Read pointer sits on the last element
      read_done_o  <= (rd_cnt >= vl_i - 1);
      wdone_o      <= closing;
      if (closing) begin
        // Unit bursts close with ready still up
        tready_o <= !strided_i;
      end else begin
        tready_o <= (armed || wstart_i) && (($random(seed) & 3) != 0);
      end
    end
  end

endmodule

//--- verification/tb_mcu_store.sv
/*
  Testbench for the store control unit with random commands,
  a reference model of the configuration rule and transfer counts
*/
`timescale 1ns/100ps

module tb_mcu_store import mcu_pkg::*; ();

  localparam int VLEN = 8192;
  localparam int CLK_PERIOD = 100;
  localparam int NUM_CMDS = 16;
  localparam int MIN_VL = 20;
  localparam int MAX_VL = 30;
  localparam int CYCLES_PER_ELEM = 16;
  localparam int WATCHDOG_CYCLES = NUM_CMDS * MAX_VL * CYCLES_PER_ELEM + 100;

  logic                    clk;
  logic                    rstn;
  logic [VTYPE_W-1:0]      mcu_sew_i;
  logic [VTYPE_W-1:0]      mcu_lmul_i;
  logic [VTYPE_W-1:0]      mcu_data_width_i;
  logic                    mcu_unit_ld_st_i;
  logic                    mcu_strided_ld_st_i;
  logic                    mcu_idx_ld_st_i;
  logic [ADDR_W-1:0]       mcu_vl_i;
  logic                    mcu_st_vld_i;
  logic                    mcu_st_rdy_o;
  logic [VTYPE_W-1:0]      cfg_store_data_sew_o;
  logic [VTYPE_W-1:0]      cfg_store_data_lmul_o;
  logic [VTYPE_W-1:0]      cfg_store_idx_sew_o;
  logic [VTYPE_W-1:0]      cfg_store_idx_lmul_o;
  logic [$clog2(VLEN)-1:0] cfg_store_vl_o;
  store_mode_e             store_type_o;
  logic                    store_cfg_update_o;
  logic                    store_cntr_rst_o;
  logic                    store_baseaddr_update_o;
  logic                    sbuff_wen_o;
  logic                    sdbuff_ren_o;
  logic                    sdbuff_read_stall_o;
  logic                    sdbuff_write_done_i;
  logic                    sdbuff_read_done_i;
  logic                    sdbuff_read_rdy_i;
  logic                    vlane_store_dvalid_i;
  logic                    vlane_store_rdy_o;
  logic                    ctrl_wstart_o;
  logic                    ctrl_wdone_i;
  logic                    wr_tvalid_o;
  logic                    wr_tready_i;

  integer             seed = 32'hf6ac;
  int                 cmd_vl = MIN_VL;
  logic               cmd_strided = 1'b0;
  logic [VTYPE_W-1:0] cmd_sew;
  logic [VTYPE_W-1:0] cmd_lmul;
  logic [VTYPE_W-1:0] cmd_width;
  int                 wen_cnt = 0;
  int                 xfer_cnt = 0;
  int                 wstart_cnt = 0;
  int                 base_cnt = 0;
  int                 cfg_cnt = 0;

  mcu_store #(.VLEN(VLEN)) i_mcu_store (.*);

  mcu_store_env #(.SEED(32'hf6ac)) i_env (
    .clk          (clk),
    .rstn         (rstn),
    .vl_i         (cmd_vl),
    .strided_i    (cmd_strided),
    .cntr_rst_i   (store_cntr_rst_o),
    .vlane_rdy_i  (vlane_store_rdy_o),
    .wen_i        (sbuff_wen_o),
    .ren_i        (sdbuff_ren_o),
    .wstart_i     (ctrl_wstart_o),
    .tvalid_i     (wr_tvalid_o),
    .dvalid_o     (vlane_store_dvalid_i),
    .write_done_o (sdbuff_write_done_i),
    .read_rdy_o   (sdbuff_read_rdy_i),
    .read_done_o  (sdbuff_read_done_i),
    .tready_o     (wr_tready_i),
    .wdone_o      (ctrl_wdone_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Reference model and checks

  // emul = lmul * eew / sew in the log2 domain, lmul codes 5..7 are fractions
  function automatic int emul_log2(input logic [2:0] lmul, input logic [2:0] width,
                                   input logic [2:0] sew);
    int lmul_log2;
    lmul_log2 = (lmul < 3'd4) ? int'(lmul) : int'(lmul) - 8;
    return lmul_log2 + int'(width) - int'(sew);
  endfunction

  function automatic bit emul_legal(input logic [2:0] lmul, input logic [2:0] width,
                                    input logic [2:0] sew);
    int e;
    e = emul_log2(lmul, width, sew);
    return (lmul != 3'd4) && (e >= -3) && (e <= 3);
  endfunction

  task automatic stop_on_error();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_idle_outputs();
    check_value("reset st_rdy", 1, mcu_st_rdy_o);
    check_value("reset sbuff_wen", 0, sbuff_wen_o);
    check_value("reset sdbuff_ren", 0, sdbuff_ren_o);
    check_value("reset read_stall", 0, sdbuff_read_stall_o);
    check_value("reset wstart", 0, ctrl_wstart_o);
    check_value("reset tvalid", 0, wr_tvalid_o);
    check_value("reset cfg_update", 0, store_cfg_update_o);
    check_value("reset cntr_rst", 0, store_cntr_rst_o);
    check_value("reset baseaddr_update", 0, store_baseaddr_update_o);
    check_value("reset vlane_rdy", 0, vlane_store_rdy_o);
  endtask

  // Random legal unit or strided command, applied to the scheduler inputs
  task automatic draw_command();
    do begin
      cmd_sew   = 3'($random(seed) & 3);
      cmd_width = 3'($random(seed) & 3);
      cmd_lmul  = 3'($random(seed));
    end while (!emul_legal(cmd_lmul, cmd_width, cmd_sew));
    cmd_vl              = MIN_VL + int'($unsigned($random(seed)) % (MAX_VL - MIN_VL + 1));
    cmd_strided         = 1'($random(seed) & 1);
    mcu_sew_i           = cmd_sew;
    mcu_lmul_i          = cmd_lmul;
    mcu_data_width_i    = cmd_width;
    mcu_unit_ld_st_i    = !cmd_strided;
    mcu_strided_ld_st_i = cmd_strided;
    mcu_idx_ld_st_i     = 1'b0;
    mcu_vl_i            = cmd_vl;
  endtask

  // Per cycle lane write check and event counters
  always @(posedge clk) begin
    if (rstn) begin
      if (vlane_store_rdy_o) begin
        check_value("lane write enable", int'(vlane_store_dvalid_i), int'(sbuff_wen_o));
      end else begin
        assert (!sbuff_wen_o) else begin
          $display("ERROR: buffer write enable high while the lanes are not served");
          stop_on_error();
        end
      end
      wen_cnt    += int'(sbuff_wen_o);
      xfer_cnt   += int'(wr_tvalid_o && wr_tready_i);
      wstart_cnt += int'(ctrl_wstart_o);
      base_cnt   += int'(store_baseaddr_update_o);
      cfg_cnt    += int'(store_cfg_update_o);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired, a store command never completed");
    stop_on_error();
  end

  ////////////////////
  // Main sequence

  initial begin
    int                 wen0;
    int                 xfer0;
    int                 wstart0;
    int                 base0;
    int                 cfg0;
    logic [VTYPE_W-1:0] exp_emul;
    string              tag;

    rstn                = 1'b0;
    mcu_sew_i           = '0;
    mcu_lmul_i          = '0;
    mcu_data_width_i    = '0;
    mcu_unit_ld_st_i    = 1'b0;
    mcu_strided_ld_st_i = 1'b0;
    mcu_idx_ld_st_i     = 1'b0;
    mcu_vl_i            = '0;
    mcu_st_vld_i        = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_idle_outputs();

    for (int i = 0; i < NUM_CMDS; i++) begin
      draw_command();
      exp_emul = 3'(emul_log2(cmd_lmul, cmd_width, cmd_sew));
      tag      = $sformatf("cmd%0d %s", i, cmd_strided ? "strided" : "unit");
      wen0     = wen_cnt;
      xfer0    = xfer_cnt;
      wstart0  = wstart_cnt;
      base0    = base_cnt;
      cfg0     = cfg_cnt;
      mcu_st_vld_i = 1'b1;
      @(negedge clk);
      mcu_st_vld_i = 1'b0;

      // One cycle after acceptance
      check_value({tag, " cfg_update"}, 1, store_cfg_update_o);
      check_value({tag, " cntr_rst"}, 1, store_cntr_rst_o);
      check_value({tag, " st_rdy busy"}, 0, mcu_st_rdy_o);
      check_value({tag, " store_type"}, cmd_strided ? MODE_STRIDED : MODE_UNIT,
                  store_type_o);
      check_value({tag, " data_sew"}, cmd_width, cfg_store_data_sew_o);
      check_value({tag, " data_lmul"}, exp_emul, cfg_store_data_lmul_o);
      check_value({tag, " idx_sew"}, cmd_width, cfg_store_idx_sew_o);
      check_value({tag, " idx_lmul"}, exp_emul, cfg_store_idx_lmul_o);
      check_value({tag, " vl"}, cmd_vl, int'(cfg_store_vl_o));
      @(negedge clk);
      check_value({tag, " cfg_update width"}, 0, store_cfg_update_o);

      while (!mcu_st_rdy_o) @(negedge clk);
      check_value({tag, " lane writes"}, cmd_vl, wen_cnt - wen0);
      check_value({tag, " transfers"}, cmd_vl, xfer_cnt - xfer0);
      check_value({tag, " wstart pulses"}, cmd_strided ? cmd_vl : 1, wstart_cnt - wstart0);
      check_value({tag, " baseaddr updates"}, cmd_strided ? cmd_vl : 0, base_cnt - base0);
      check_value({tag, " cfg_update pulses"}, 1, cfg_cnt - cfg0);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
